// File: hw/colmix_pkg.sv
// color mixer shared definitions
package colmix_pkg;

    // layer pixel: bank over color
    localparam int pxl_w = 8;
    localparam int col_w = 4;

    // palette entry, blue high, green middle, red low
    localparam int rgb5_w = 15;

    // palette depth, overridden from the top level
    localparam int pal_aw_default = 10;

    // apb address map
    localparam int          apb_aw       = 13;
    localparam int          reg_base     = 12;
    localparam logic [12:0] reg_ctrl_off = 13'h1000;
    localparam logic [12:0] reg_id_off   = 13'h1004;
    localparam logic [31:0] id_value     = 32'h0C01_0251;

    // control register fields
    localparam int ctrl_w       = 5;
    localparam int ctrl_prio_b  = 0;
    localparam int ctrl_shadow_b = 1;
    localparam int ctrl_dim_lsb = 2;
    localparam int dim_w        = 3;

    // layer order behind the fix layer
    localparam logic prio_fix_obj_scr = 1'b0;
    localparam logic prio_fix_scr_obj = 1'b1;

    // object color used as a shadow mask
    localparam logic [3:0] shadow_color = 4'd15;

    // layer numbers placed above the pixel in the palette address
    localparam int lyr_fix = 1;
    localparam int lyr_obj = 2;
    localparam int lyr_scr = 3;

endpackage

// File: hw/colmix_apb_regs.sv
// APB palette and control registers
`timescale 1ns/100ps

module colmix_apb_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [colmix_pkg::apb_aw-1:0]       paddr,
    input  logic [31:0]                         pwdata,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr,
    // palette cpu port
    output logic                                cpu_we,
    output logic [colmix_pkg::reg_base-3:0]     cpu_addr,
    output logic [colmix_pkg::rgb5_w-1:0]       cpu_wdata,
    input  logic [colmix_pkg::rgb5_w-1:0]       cpu_rdata,
    // mixer controls
    output logic                                prio_order,
    output logic                                shadow_en,
    output logic [colmix_pkg::dim_w-1:0]        dim
);

    logic                            access;
    logic                            reg_sel;
    logic                            ctrl_hit;
    logic                            id_hit;
    logic                            pal_rd;
    logic                            rd_wait;
    logic [colmix_pkg::ctrl_w-1:0]   ctrl;

    assign access   = psel & penable;
    assign reg_sel  = paddr[colmix_pkg::reg_base];
    assign ctrl_hit = (paddr == colmix_pkg::reg_ctrl_off);
    assign id_hit   = (paddr == colmix_pkg::reg_id_off);
    assign pal_rd   = access & ~pwrite & ~reg_sel;

    // palette reads wait one cycle for the registered RAM output
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_wait <= 1'b0;
        end else begin
            rd_wait <= pal_rd & ~rd_wait;
        end
    end

    assign pready  = access & (pwrite | reg_sel | rd_wait);
    assign pslverr = pready & reg_sel & ~ctrl_hit & ~id_hit;

    // palette write port, one cycle per transfer
    assign cpu_we    = access & pwrite & ~reg_sel;
    assign cpu_addr  = paddr[colmix_pkg::reg_base-1:2];
    assign cpu_wdata = pwdata[colmix_pkg::rgb5_w-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl <= '0;
        end else if (access & pwrite & ctrl_hit) begin
            ctrl <= pwdata[colmix_pkg::ctrl_w-1:0];
        end
    end

    always_comb begin
        prdata = '0;
        if (!reg_sel) begin
            prdata[colmix_pkg::rgb5_w-1:0] = cpu_rdata;
        end else if (ctrl_hit) begin
            prdata[colmix_pkg::ctrl_w-1:0] = ctrl;
        end else if (id_hit) begin
            prdata = colmix_pkg::id_value;
        end
    end

    assign prio_order = ctrl[colmix_pkg::ctrl_prio_b];
    assign shadow_en  = ctrl[colmix_pkg::ctrl_shadow_b];
    assign dim        = ctrl[colmix_pkg::ctrl_dim_lsb +: colmix_pkg::dim_w];

endmodule

// File: hw/layer_prio_mux.sv
// layer priority and transparency mixer
`timescale 1ns/100ps

module layer_prio_mux #(
    parameter int pal_aw = colmix_pkg::pal_aw_default
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    input  logic                         lhbl,
    input  logic                         lvbl,
    input  logic [colmix_pkg::pxl_w-1:0] fix_pxl,
    input  logic [colmix_pkg::pxl_w-1:0] obj_pxl,
    input  logic [colmix_pkg::pxl_w-1:0] scr_pxl,
    input  logic                         prio_order,
    input  logic                         shadow_en,
    output logic [pal_aw-1:0]            pal_addr,
    output logic                         shadow_px,
    output logic                         vis_px
);

    localparam int lyr_w = pal_aw - colmix_pkg::pxl_w;

    logic              fix_op;
    logic              obj_op;
    logic              scr_op;
    logic              obj_shd;
    logic              obj_first;
    logic              shd_hit;
    logic [pal_aw-1:0] addr_nx;

    // color 0 is transparent on every layer
    assign fix_op  = |fix_pxl[colmix_pkg::col_w-1:0];
    assign scr_op  = |scr_pxl[colmix_pkg::col_w-1:0];
    assign obj_shd = shadow_en & (obj_pxl[colmix_pkg::col_w-1:0] == colmix_pkg::shadow_color);
    assign obj_op  = |obj_pxl[colmix_pkg::col_w-1:0] & ~obj_shd;

    // object ahead of scroll in the current order
    assign obj_first = (prio_order == colmix_pkg::prio_fix_obj_scr);

    // shadow object that would have been on top
    assign shd_hit = obj_shd & ~fix_op & (obj_first | ~scr_op);

    always_comb begin
        addr_nx = '0;
        if (fix_op) begin
            addr_nx = {lyr_w'(colmix_pkg::lyr_fix), fix_pxl};
        end else if (obj_first) begin
            if (obj_op)
                addr_nx = {lyr_w'(colmix_pkg::lyr_obj), obj_pxl};
            else if (scr_op)
                addr_nx = {lyr_w'(colmix_pkg::lyr_scr), scr_pxl};
        end else begin
            if (scr_op)
                addr_nx = {lyr_w'(colmix_pkg::lyr_scr), scr_pxl};
            else if (obj_op)
                addr_nx = {lyr_w'(colmix_pkg::lyr_obj), obj_pxl};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shadow_px <= 1'b0;
            vis_px    <= 1'b0;
        end else if (pxl_cen) begin
            shadow_px <= shd_hit;
            vis_px    <= lhbl & lvbl;
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen)
            pal_addr <= addr_nx;
    end

endmodule

// File: hw/pal_ram.sv
// dual port palette memory
`timescale 1ns/100ps

module pal_ram #(
    parameter int pal_aw = colmix_pkg::pal_aw_default
) (
    input  logic                          clk,
    input  logic                          pxl_cen,
    // cpu side
    input  logic                          cpu_we,
    input  logic [pal_aw-1:0]             cpu_addr,
    input  logic [colmix_pkg::rgb5_w-1:0] cpu_wdata,
    output logic [colmix_pkg::rgb5_w-1:0] cpu_rdata,
    // pixel lookup side
    input  logic [pal_aw-1:0]             pal_addr,
    output logic [colmix_pkg::rgb5_w-1:0] pix_rgb5
);

    localparam int depth = 2 ** pal_aw;

    logic [colmix_pkg::rgb5_w-1:0] mem [depth];

    // cpu port, read before write
    always_ff @(posedge clk) begin
        if (cpu_we)
            mem[cpu_addr] <= cpu_wdata;
        cpu_rdata <= mem[cpu_addr];
    end

    // lookup only moves with the pixel clock enable
    always_ff @(posedge clk) begin
        if (pxl_cen)
            pix_rgb5 <= mem[pal_addr];
    end

endmodule

// File: hw/color_out.sv
// RGB output stage with shadow and dimming
`timescale 1ns/100ps

module color_out (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pxl_cen,
    input  logic [colmix_pkg::rgb5_w-1:0] pix_rgb5,
    input  logic                          shadow_px,
    input  logic                          vis_px,
    input  logic [colmix_pkg::dim_w-1:0]  dim,
    output logic [7:0]                    red,
    output logic [7:0]                    green,
    output logic [7:0]                    blue
);

    logic shadow_d;
    logic vis_d;

    // expand, halve when shadowed, then scale by (8 - dim) / 8
    function automatic logic [7:0] chan_out(
        input logic [4:0]                     c5,
        input logic                           shd,
        input logic [colmix_pkg::dim_w-1:0]   dm
    );
        logic [7:0]  c8;
        logic [3:0]  gain;
        logic [11:0] prod;
        c8   = {c5, c5[4:2]};
        if (shd)
            c8 = c8 >> 1;
        gain = 4'd8 - {1'b0, dm};
        prod = c8 * gain;
        return prod[10:3];
    endfunction

    // flags wait one stage for the palette lookup
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shadow_d <= 1'b0;
            vis_d    <= 1'b0;
        end else if (pxl_cen) begin
            shadow_d <= shadow_px;
            vis_d    <= vis_px;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            if (vis_d) begin
                red   <= chan_out(pix_rgb5[4:0], shadow_d, dim);
                green <= chan_out(pix_rgb5[9:5], shadow_d, dim);
                blue  <= chan_out(pix_rgb5[14:10], shadow_d, dim);
            end else begin
                // blanking
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

// File: hw/colmix_top.sv
// color mixer top level
`timescale 1ns/100ps

module colmix_top #(
    parameter int pal_aw = colmix_pkg::pal_aw_default
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pxl_cen,
    input  logic                          lhbl,
    input  logic                          lvbl,
    input  logic [colmix_pkg::pxl_w-1:0]  fix_pxl,
    input  logic [colmix_pkg::pxl_w-1:0]  obj_pxl,
    input  logic [colmix_pkg::pxl_w-1:0]  scr_pxl,
    // apb slave
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [colmix_pkg::apb_aw-1:0] paddr,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    // video out
    output logic [7:0]                    red,
    output logic [7:0]                    green,
    output logic [7:0]                    blue
);

    logic                             cpu_we;
    logic [pal_aw-1:0]                cpu_addr;
    logic [colmix_pkg::rgb5_w-1:0]    cpu_wdata;
    logic [colmix_pkg::rgb5_w-1:0]    cpu_rdata;
    logic                             prio_order;
    logic                             shadow_en;
    logic [colmix_pkg::dim_w-1:0]     dim;
    logic [pal_aw-1:0]                pal_addr;
    logic                             shadow_px;
    logic                             vis_px;
    logic [colmix_pkg::rgb5_w-1:0]    pix_rgb5;

    colmix_apb_regs colmix_apb_regs_inst (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_rdata  (cpu_rdata),
        .prio_order (prio_order),
        .shadow_en  (shadow_en),
        .dim        (dim)
    );

    layer_prio_mux #(
        .pal_aw (pal_aw)
    ) layer_prio_mux_inst (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .lhbl       (lhbl),
        .lvbl       (lvbl),
        .fix_pxl    (fix_pxl),
        .obj_pxl    (obj_pxl),
        .scr_pxl    (scr_pxl),
        .prio_order (prio_order),
        .shadow_en  (shadow_en),
        .pal_addr   (pal_addr),
        .shadow_px  (shadow_px),
        .vis_px     (vis_px)
    );

    pal_ram #(
        .pal_aw (pal_aw)
    ) pal_ram_inst (
        .clk       (clk),
        .pxl_cen   (pxl_cen),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .pal_addr  (pal_addr),
        .pix_rgb5  (pix_rgb5)
    );

    color_out color_out_inst (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .pix_rgb5  (pix_rgb5),
        .shadow_px (shadow_px),
        .vis_px    (vis_px),
        .dim       (dim),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule

// File: dv/colmix_checker.sv
// color mixer bus and video assertions
`timescale 1ns/100ps

module colmix_checker (
    input logic       clk,
    input logic       rst,
    input logic       psel,
    input logic       penable,
    input logic       pready,
    input logic       pslverr,
    input logic       pxl_cen,
    input logic       vis_d,
    input logic [7:0] red,
    input logic [7:0] green,
    input logic [7:0] blue
);

    // apb handshake
    pready_in_access: assert property (@(posedge clk) disable iff (rst)
        pready |-> (psel && penable))
        else $error("pready high outside an access cycle");

    pslverr_with_pready: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> pready)
        else $error("pslverr high without pready");

    // a blanked pixel leaves the output stage as black
    blank_is_black: assert property (@(posedge clk) disable iff (rst)
        (pxl_cen && !vis_d) |=> (red == 8'h00 && green == 8'h00 && blue == 8'h00))
        else $error("color output not black after a blanked pixel");

endmodule

bind colmix_apb_regs colmix_checker apb_chk (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .pxl_cen (1'b0),
    .vis_d   (1'b1),
    .red     (8'h00),
    .green   (8'h00),
    .blue    (8'h00)
);

bind color_out colmix_checker video_chk (
    .clk     (clk),
    .rst     (rst),
    .psel    (1'b0),
    .penable (1'b0),
    .pready  (1'b0),
    .pslverr (1'b0),
    .pxl_cen (pxl_cen),
    .vis_d   (vis_d),
    .red     (red),
    .green   (green),
    .blue    (blue)
);

// File: dv/colmix_tb.sv
// color mixer testbench
`timescale 1ns/100ps

module colmix_tb;

    localparam int n_fill  = 1024;
    localparam int n_rd    = 200;
    localparam int n_run   = 400;
    localparam int n_apb   = n_fill + n_rd + 44;
    localparam int n_pix   = 6 * n_run;
    // four cycles of 40 ns per transfer or pixel, plus margin
    localparam int wd_ns   = (n_apb + n_pix) * 4 * 40 + 20000;

    logic        clk;
    logic        rst;
    logic        pxl_cen;
    logic        lhbl;
    logic        lvbl;
    logic [7:0]  fix_pxl;
    logic [7:0]  obj_pxl;
    logic [7:0]  scr_pxl;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [12:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;

    // reference model state
    logic [14:0] pal_mdl [1024];
    logic [4:0]  ctrl_mdl;
    logic [23:0] exp_q [$];

    colmix_top colmix_top_inst (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .lhbl    (lhbl),
        .lvbl    (lvbl),
        .fix_pxl (fix_pxl),
        .obj_pxl (obj_pxl),
        .scr_pxl (scr_pxl),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

    always #20 clk = ~clk;

    initial begin
        #(wd_ns);
        $display("timeout: the run did not finish within %0d ns", wd_ns);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_idle_outputs();
        check_val("red", 0, red);
        check_val("green", 0, green);
        check_val("blue", 0, blue);
        check_val("pready", 0, pready);
        check_val("pslverr", 0, pslverr);
    endtask

    // one apb transfer, outputs sampled mid cycle before the closing edge
    task automatic apb_xfer(input logic wr, input logic [12:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rd, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #10;
        while (!pready) begin
            @(negedge clk);
            #10;
        end
        rd  = prdata;
        err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic set_ctrl(input logic [4:0] value);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, 13'h1000, {27'd0, value}, rd, err);
        check_val("pslverr", 0, err);
        ctrl_mdl = value;
    endtask

    // first opaque layer in the current order, shadow objects skipped
    function automatic logic [10:0] mix_model(input logic [7:0] f, input logic [7:0] o,
                                              input logic [7:0] s);
        logic [7:0] px;
        logic [9:0] addr;
        logic       shd;
        logic       found;
        int         i;
        int         lyr;
        addr  = '0;
        shd   = 1'b0;
        found = 1'b0;
        for (i = 0; i < 3; i++) begin
            lyr = ctrl_mdl[0] ? ((i == 0) ? 1 : 4 - i) : i + 1;
            px  = (lyr == 1) ? f : (lyr == 2) ? o : s;
            if (!found && px[3:0] != 4'h0) begin
                if (lyr == 2 && ctrl_mdl[1] && px[3:0] == 4'hf) begin
                    shd = 1'b1;
                end else begin
                    addr  = {lyr[1:0], px};
                    found = 1'b1;
                end
            end
        end
        return {shd, addr};
    endfunction

    // red, green, blue packed high to low
    function automatic logic [23:0] color_model(input logic [14:0] rgb, input logic shd,
                                                input logic vis);
        logic [23:0] res;
        logic [4:0]  c5;
        int          c;
        int          k;
        res = '0;
        for (k = 0; k < 3; k++) begin
            c5 = rgb[k*5 +: 5];
            // top three bits repeated below the five
            c  = c5 * 8 + c5 / 4;
            if (shd)
                c = c / 2;
            c   = (c * (8 - ctrl_mdl[4:2])) / 8;
            res = {res[15:0], 8'(c)};
        end
        return vis ? res : 24'h0;
    endfunction

    function automatic logic [7:0] rand_pxl(input logic shd_bias);
        logic [7:0] p;
        p = 8'($urandom);
        if ($urandom % 3 == 0)
            p[3:0] = 4'h0;
        else if (shd_bias && $urandom % 2 == 0)
            p[3:0] = 4'hf;
        return p;
    endfunction

    // random pixels; each strobe is checked two strobes later
    task automatic run_pixels(input int count, input logic shd_bias, input logic gaps);
        logic [10:0] m;
        int          done_cnt;
        exp_q.delete();
        done_cnt = 0;
        while (done_cnt < count) begin
            @(negedge clk);
            if (pxl_cen) begin
                m = mix_model(fix_pxl, obj_pxl, scr_pxl);
                exp_q.push_back(color_model(pal_mdl[m[9:0]], m[10], lhbl & lvbl));
                if (exp_q.size() == 3)
                    check_val("rgb", {8'h0, exp_q.pop_front()}, {8'h0, red, green, blue});
                done_cnt++;
            end
            pxl_cen = ($urandom % 2 == 0);
            fix_pxl = rand_pxl(1'b0);
            obj_pxl = rand_pxl(shd_bias);
            scr_pxl = rand_pxl(1'b0);
            lhbl    = gaps ? ($urandom % 6 != 0) : 1'b1;
            lvbl    = gaps ? ($urandom % 10 != 0) : 1'b1;
        end
        @(negedge clk);
        pxl_cen = 1'b0;
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] wd;
        logic        err;
        logic [12:0] bad;
        int          a;
        void'($urandom(32'h2c5c));
        clk = 1'b0;
        rst = 1'b1;
        pxl_cen = 1'b0;
        lhbl = 1'b1;
        lvbl = 1'b1;
        fix_pxl = '0;
        obj_pxl = '0;
        scr_pxl = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        ctrl_mdl = '0;
        repeat (10) begin
            @(negedge clk);
            check_idle_outputs();
        end
        rst = 1'b0;
        @(negedge clk);
        check_idle_outputs();

        // palette fill and random read back
        for (a = 0; a < n_fill; a++) begin
            wd = $urandom;
            apb_xfer(1'b1, {1'b0, 10'(a), 2'b00}, wd, rd, err);
            check_val("pslverr", 0, err);
            pal_mdl[a] = wd[14:0];
        end
        repeat (n_rd) begin
            a = $urandom % n_fill;
            apb_xfer(1'b0, {1'b0, 10'(a), 2'b00}, 0, rd, err);
            check_val("pslverr", 0, err);
            check_val("prdata", {17'd0, pal_mdl[a]}, rd);
        end

        // control, id and unmapped registers
        repeat (8) begin
            set_ctrl(5'($urandom));
            apb_xfer(1'b0, 13'h1000, 0, rd, err);
            check_val("prdata", {27'd0, ctrl_mdl}, rd);
        end
        apb_xfer(1'b0, 13'h1004, 0, rd, err);
        check_val("prdata", 32'h0C01_0251, rd);
        check_val("pslverr", 0, err);
        repeat (6) begin
            bad = {1'b1, 12'($urandom)};
            if (bad == 13'h1000 || bad == 13'h1004)
                bad = 13'h1ffc;
            apb_xfer(1'b1, bad, $urandom, rd, err);
            check_val("pslverr", 1, err);
            apb_xfer(1'b0, bad, 0, rd, err);
            check_val("pslverr", 1, err);
            check_val("prdata", 0, rd);
            apb_xfer(1'b0, 13'h1000, 0, rd, err);
            check_val("prdata", {27'd0, ctrl_mdl}, rd);
        end

        // priority, shadow, then dimming with blanking gaps
        set_ctrl(5'b000_0_0);
        run_pixels(n_run, 1'b0, 1'b0);
        set_ctrl(5'b000_0_1);
        run_pixels(n_run, 1'b0, 1'b0);
        set_ctrl(5'b000_1_0);
        run_pixels(n_run, 1'b1, 1'b0);
        set_ctrl(5'b000_1_1);
        run_pixels(n_run, 1'b1, 1'b0);
        set_ctrl(5'b000_0_0);
        run_pixels(n_run, 1'b1, 1'b0);
        repeat (4) begin
            set_ctrl(5'($urandom));
            run_pixels(n_run / 4, 1'b1, 1'b1);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: colmix.f
hw/colmix_pkg.sv
hw/colmix_apb_regs.sv
hw/layer_prio_mux.sv
hw/pal_ram.sv
hw/color_out.sv
hw/colmix_top.sv
dv/colmix_checker.sv
dv/colmix_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the color mixer simulation with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module colmix_tb -f colmix.f -o colmix_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/colmix_sim > "$log" 2>&1
run_status=$?
cat "$log"

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    echo "TEST FAIL"
    exit 1
fi

if grep -q "TEST FAIL" "$log"; then
    exit 1
fi
exit 0
